//--- rtl/cpu_front_pkg.sv
package cpu_front_pkg;

    // Address and instruction widths
    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;

    // Fetch block of four words, two commit lanes
    localparam int FETCH_WIDTH  = 4;
    localparam int RETIRE_WIDTH = 2;
    localparam int BLOCK_W      = FETCH_WIDTH * INSTR_W;

    // Word select and byte offset inside a fetch block
    localparam int WORD_SEL_W  = $clog2(FETCH_WIDTH);
    localparam int BLOCK_OFS_W = WORD_SEL_W + 2;

    // Instruction buffer sizing, also the full credit count
    localparam int IB_DEPTH = 16;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);
    localparam int CREDIT_W = $clog2(IB_DEPTH + 1);

    // Count of entries offered at the buffer head, 0 to RETIRE_WIDTH
    localparam int HEAD_W = $clog2(RETIRE_WIDTH + 1);

    // First fetched address after reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h1c00_0000;

    // Major opcode of LoongArch B
    localparam logic [5:0] OPC_B = 6'b010100;

    // One buffered instruction with its address
    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
    } ib_entry_t;

endpackage

//--- rtl/fetch_unit.sv
module fetch_unit
    import cpu_front_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        imem_valid_i,
    input  logic [BLOCK_W-1:0]          imem_data_i,
    input  logic [CREDIT_W-1:0]         push_credit_i,
    input  logic                        redirect_i,
    input  logic [ADDR_W-1:0]           redirect_pc_i,
    output logic                        imem_req_o,
    output logic [ADDR_W-1:0]           imem_addr_o,
    output logic                        push_valid_o,
    output logic [FETCH_WIDTH-1:0]      push_mask_o,
    output ib_entry_t [FETCH_WIDTH-1:0] push_entries_o
);

    logic [ADDR_W-1:0]   pc;
    logic [ADDR_W-1:0]   pc_next;
    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_next;
    logic                outstanding;
    logic                stale;
    logic                issue;

    // An answer is dropped if a redirect came after its request
    assign push_valid_o = imem_valid_i & ~stale & ~redirect_i;

    // Split the block into word entries, skip words before the PC offset
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            push_entries_o[k].pc    = {pc[ADDR_W-1:BLOCK_OFS_W], WORD_SEL_W'(k), 2'b00};
            push_entries_o[k].instr = imem_data_i[k*INSTR_W +: INSTR_W];
            push_mask_o[k]          = (WORD_SEL_W'(k) >= pc[BLOCK_OFS_W-1:2]);
        end
    end

    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (push_valid_o) begin
            pc_next = {pc[ADDR_W-1:BLOCK_OFS_W] + 1'b1, BLOCK_OFS_W'(0)};
        end else begin
            pc_next = pc;
        end
    end

    // One request in flight, the next one may follow the answer directly
    assign issue = ~redirect_i & ~imem_req_o & (~outstanding | imem_valid_i) &
                   (credits >= CREDIT_W'(FETCH_WIDTH));

    assign credits_next = redirect_i ? CREDIT_W'(IB_DEPTH) :
                          credits + push_credit_i - (issue ? CREDIT_W'(FETCH_WIDTH) : '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc          <= RESET_PC;
            credits     <= CREDIT_W'(IB_DEPTH);
            outstanding <= 1'b0;
            stale       <= 1'b0;
            imem_req_o  <= 1'b0;
        end else begin
            pc         <= pc_next;
            credits    <= credits_next;
            imem_req_o <= issue;
            if (imem_req_o) begin
                outstanding <= 1'b1;
            end else if (imem_valid_i) begin
                outstanding <= 1'b0;
            end
            // Request still on its way when the stream changes
            if (redirect_i) begin
                stale <= imem_req_o | (outstanding & ~imem_valid_i);
            end else if (imem_valid_i) begin
                stale <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            imem_addr_o <= {pc_next[ADDR_W-1:BLOCK_OFS_W], BLOCK_OFS_W'(0)};
        end
    end

endmodule

//--- rtl/instr_buffer.sv
module instr_buffer
    import cpu_front_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         flush_i,
    input  logic                         push_valid_i,
    input  logic [FETCH_WIDTH-1:0]       push_mask_i,
    input  ib_entry_t [FETCH_WIDTH-1:0]  push_entries_i,
    input  logic [HEAD_W-1:0]            pop_count_i,
    output logic [HEAD_W-1:0]            head_count_o,
    output ib_entry_t [RETIRE_WIDTH-1:0] head_entries_o,
    output logic [CREDIT_W-1:0]          credit_ret_o
);

    ib_entry_t           mem [IB_DEPTH];
    logic [IB_PTR_W-1:0] rd_ptr;
    logic [IB_PTR_W-1:0] wr_ptr;
    logic [CREDIT_W-1:0] count;
    logic [CREDIT_W-1:0] push_num;
    logic [CREDIT_W-1:0] push_cnt;
    logic                push_en;
    logic [IB_PTR_W-1:0] slot [FETCH_WIDTH];

    assign push_en = push_valid_i & ~flush_i;

    // Compact the kept words onto consecutive slots from the write pointer
    always_comb begin
        push_num = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            slot[k] = wr_ptr + IB_PTR_W'(push_num);
            if (push_mask_i[k]) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    assign push_cnt = push_en ? push_num : '0;

    // Popped entries and unused push slots go back to fetch
    assign credit_ret_o = CREDIT_W'(pop_count_i) +
                          (push_valid_i ? CREDIT_W'(FETCH_WIDTH) - push_num : '0);

    // Oldest entries, at most two offered
    assign head_count_o = (count >= CREDIT_W'(RETIRE_WIDTH)) ? HEAD_W'(RETIRE_WIDTH)
                                                             : count[HEAD_W-1:0];

    always_comb begin
        for (int k = 0; k < RETIRE_WIDTH; k++) begin
            head_entries_o[k] = mem[rd_ptr + IB_PTR_W'(k)];
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                if (push_mask_i[k]) begin
                    mem[slot[k]] <= push_entries_i[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + IB_PTR_W'(push_cnt);
            rd_ptr <= rd_ptr + IB_PTR_W'(pop_count_i);
            count  <= count + push_cnt - CREDIT_W'(pop_count_i);
        end
    end

endmodule

//--- rtl/retire_unit.sv
module retire_unit
    import cpu_front_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 commit_stall_i,
    input  logic [HEAD_W-1:0]                    head_count_i,
    input  ib_entry_t [RETIRE_WIDTH-1:0]         head_entries_i,
    output logic [HEAD_W-1:0]                    pop_count_o,
    output logic                                 redirect_o,
    output logic [ADDR_W-1:0]                    redirect_pc_o,
    output logic [RETIRE_WIDTH-1:0]              commit_valid_o,
    output logic [RETIRE_WIDTH-1:0][ADDR_W-1:0]  commit_pc_o,
    output logic [RETIRE_WIDTH-1:0][INSTR_W-1:0] commit_instr_o
);

    function automatic logic is_b(input logic [INSTR_W-1:0] instr);
        return instr[INSTR_W-1 -: 6] == OPC_B;
    endfunction

    // PC plus offs26 times four, offset high part sits in bits 9:0
    function automatic logic [ADDR_W-1:0] b_target(input ib_entry_t e);
        logic [25:0] offs;
        offs = {e.instr[9:0], e.instr[25:10]};
        return e.pc + {{(ADDR_W-28){offs[25]}}, offs, 2'b00};
    endfunction

    logic lane0_b;
    logic lane1_b;
    logic take_b;

    assign lane0_b = is_b(head_entries_i[0].instr);
    assign lane1_b = is_b(head_entries_i[1].instr);

    // A B in lane 0 holds back lane 1
    always_comb begin
        if (redirect_o || commit_stall_i || head_count_i == '0) begin
            pop_count_o = '0;
        end else if (lane0_b || head_count_i == HEAD_W'(1)) begin
            pop_count_o = HEAD_W'(1);
        end else begin
            pop_count_o = HEAD_W'(2);
        end
    end

    assign take_b = ((pop_count_o != '0) & lane0_b) | ((pop_count_o == HEAD_W'(2)) & lane1_b);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_valid_o <= '0;
            redirect_o     <= 1'b0;
        end else begin
            commit_valid_o <= {pop_count_o == HEAD_W'(2), pop_count_o != '0};
            redirect_o     <= take_b;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < RETIRE_WIDTH; k++) begin
            commit_pc_o[k]    <= head_entries_i[k].pc;
            commit_instr_o[k] <= head_entries_i[k].instr;
        end
        if (take_b) begin
            redirect_pc_o <= lane0_b ? b_target(head_entries_i[0]) : b_target(head_entries_i[1]);
        end
    end

endmodule

//--- rtl/cpu_front_top.sv
module cpu_front_top
    import cpu_front_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 imem_valid_i,
    input  logic [BLOCK_W-1:0]                   imem_data_i,
    input  logic                                 commit_stall_i,
    output logic                                 imem_req_o,
    output logic [ADDR_W-1:0]                    imem_addr_o,
    output logic [RETIRE_WIDTH-1:0]              commit_valid_o,
    output logic [RETIRE_WIDTH-1:0][ADDR_W-1:0]  commit_pc_o,
    output logic [RETIRE_WIDTH-1:0][INSTR_W-1:0] commit_instr_o
);

    // Fetch to buffer
    logic                         push_valid;
    logic [FETCH_WIDTH-1:0]       push_mask;
    ib_entry_t [FETCH_WIDTH-1:0]  push_entries;
    logic [CREDIT_W-1:0]          credit_ret;

    // Buffer to retire
    logic [HEAD_W-1:0]            head_count;
    ib_entry_t [RETIRE_WIDTH-1:0] head_entries;
    logic [HEAD_W-1:0]            pop_count;

    // Branch redirect back to fetch, also flushes the buffer
    logic                         redirect;
    logic [ADDR_W-1:0]            redirect_pc;

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .imem_valid_i  (imem_valid_i),
        .imem_data_i   (imem_data_i),
        .push_credit_i (credit_ret),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .push_valid_o  (push_valid),
        .push_mask_o   (push_mask),
        .push_entries_o(push_entries)
    );

    instr_buffer u_instr_buffer (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (redirect),
        .push_valid_i  (push_valid),
        .push_mask_i   (push_mask),
        .push_entries_i(push_entries),
        .pop_count_i   (pop_count),
        .head_count_o  (head_count),
        .head_entries_o(head_entries),
        .credit_ret_o  (credit_ret)
    );

    retire_unit u_retire_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .commit_stall_i(commit_stall_i),
        .head_count_i  (head_count),
        .head_entries_i(head_entries),
        .pop_count_o   (pop_count),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o),
        .commit_instr_o(commit_instr_o)
    );

endmodule

//--- verification/cpu_front_assert.sv
module cpu_front_assert
    import cpu_front_pkg::*;
(
    input logic                    clk,
    input logic                    rst_i,
    input logic [CREDIT_W-1:0]     credits_i,
    input logic                    req_i,
    input logic                    outstanding_i,
    input logic [RETIRE_WIDTH-1:0] lane_valid_i,
    input logic [INSTR_W-1:0]      lane0_instr_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Credits only come back for slots that were handed out
    credit_bound: assert property (@(posedge clk) disable iff (rst_i)
        credits_i <= CREDIT_W'(IB_DEPTH))
        else $error("fetch credit count above buffer depth");

    req_single: assert property (@(posedge clk) disable iff (rst_i)
        req_i |-> !outstanding_i)
        else $error("memory request while another one is outstanding");

    // Lane 1 only follows a committed lane 0 that is not a B
    lane_order: assert property (@(posedge clk) disable iff (rst_i)
        lane_valid_i[1] |-> lane_valid_i[0] && (lane0_instr_i[INSTR_W-1 -: 6] != OPC_B))
        else $error("commit lane 1 valid without lane 0 or behind a B");

endmodule

bind fetch_unit cpu_front_assert u_assert (
    .clk(clk), .rst_i(rst_i), .credits_i(credits), .req_i(imem_req_o),
    .outstanding_i(outstanding), .lane_valid_i('0), .lane0_instr_i('0)
);

// Retire side only drives the lane check
bind retire_unit cpu_front_assert u_assert (
    .clk(clk), .rst_i(rst_i), .credits_i('0), .req_i(1'b0),
    .outstanding_i(1'b0), .lane_valid_i(commit_valid_o),
    .lane0_instr_i(commit_instr_o[0])
);

//--- verification/tb_cpu_front.sv
module tb_cpu_front
    import cpu_front_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                                 clk;
    logic                                 rst_i;
    logic                                 imem_valid_i;
    logic [BLOCK_W-1:0]                   imem_data_i;
    logic                                 commit_stall_i;
    logic                                 imem_req_o;
    logic [ADDR_W-1:0]                    imem_addr_o;
    logic [RETIRE_WIDTH-1:0]              commit_valid_o;
    logic [RETIRE_WIDTH-1:0][ADDR_W-1:0]  commit_pc_o;
    logic [RETIRE_WIDTH-1:0][INSTR_W-1:0] commit_instr_o;

    // Memory image and expected commit trace
    logic [INSTR_W-1:0] imem [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0]  exp_pc [$];
    logic [INSTR_W-1:0] exp_instr [$];

    int                 seed = 32'h2590_019f;
    int                 errors;
    int                 timeouts;
    int                 commits_seen;
    int                 cycles;
    int                 delay;
    int                 stall_left;
    bit                 busy;
    bit                 req_seen;
    logic [ADDR_W-1:0]  req_addr;

    cpu_front_top i_cpu_front_top (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Words outside the image get a pattern from their address
    function automatic logic [INSTR_W-1:0] read_word(input logic [ADDR_W-1:0] a);
        return imem.exists(a) ? imem[a] : a ^ 32'h5a5a_a5a5;
    endfunction

    // Memory model, stall stimulus and commit monitor
    initial begin
        imem_valid_i   = 1'b0;
        imem_data_i    = '0;
        commit_stall_i = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            imem_valid_i = 1'b0;
            if (busy) begin
                delay--;
                if (delay == 0) begin
                    busy         = 1'b0;
                    imem_valid_i = 1'b1;
                    for (int k = 0; k < FETCH_WIDTH; k++) begin
                        imem_data_i[k*INSTR_W +: INSTR_W] = read_word(req_addr + ADDR_W'(4 * k));
                    end
                end
            end
            if (imem_req_o) begin
                if (!req_seen) begin
                    compare_value(imem_addr_o, RESET_PC, "first fetch address");
                end
                req_seen = 1'b1;
                busy     = 1'b1;
                req_addr = imem_addr_o;
                delay    = 1 + int'($unsigned($random(seed)) % 4);
            end
            // Stall in stretches of up to 40 cycles
            if (stall_left == 0) begin
                stall_left     = 1 + int'($unsigned($random(seed)) % 40);
                commit_stall_i = ($unsigned($random(seed)) % 3) == 0;
            end
            stall_left--;
            if (!req_seen) begin
                compare_value(32'(commit_valid_o), '0, "commit before first fetch");
            end else begin
                for (int k = 0; k < RETIRE_WIDTH; k++) begin
                    if (commit_valid_o[k] && commits_seen < exp_pc.size()) begin
                        compare_value(commit_pc_o[k], exp_pc[commits_seen], "commit pc");
                        compare_value(commit_instr_o[k], exp_instr[commits_seen], "commit instr");
                        commits_seen++;
                    end
                end
            end
        end
    end

    initial begin
        int                 fd;
        string              line;
        byte                kind;
        logic [ADDR_W-1:0]  addr;
        logic [INSTR_W-1:0] word;
        rst_i = 1'b1;
        fd = $fopen("verification/front_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                // Comment lines fail the scan and are skipped
                if ($fgets(line, fd) != 0) begin
                    if ($sscanf(line, "%c %h %h", kind, addr, word) == 3) begin
                        if (kind == "M") begin
                            imem[addr] = word;
                        end else if (kind == "E") begin
                            exp_pc.push_back(addr);
                            exp_instr.push_back(word);
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (exp_pc.size() == 0) begin
            $display("No expected commits could be read from verification/front_tests.txt");
            $display("Result: FAILED");
        end else begin
            repeat (4) @(posedge clk);
            #2;
            rst_i = 1'b0;
            // Generous bound, stall stretches dominate the run time
            while (commits_seen < exp_pc.size() && cycles < 5000) begin
                @(posedge clk);
                cycles++;
            end
            if (commits_seen < exp_pc.size()) begin
                timeouts++;
                $display("Timeout: only %0d of %0d expected commits seen after %0d cycles",
                         commits_seen, exp_pc.size(), cycles);
            end
            $display("Commits checked: %0d, errors: %0d, timeouts: %0d",
                     commits_seen, errors, timeouts);
            if (errors == 0 && timeouts == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

endmodule

//--- src.f
rtl/cpu_front_pkg.sv
rtl/fetch_unit.sv
rtl/instr_buffer.sv
rtl/retire_unit.sv
rtl/cpu_front_top.sv
verification/cpu_front_assert.sv
verification/tb_cpu_front.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_cpu_front
FILELIST = src.f
BIN      = obj_dir/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
LOG      = sim.log

.PHONY: run clean

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) && ! grep -q "Result: FAILED" $(LOG)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/front_tests.txt
# M lines hold address and word of the instruction memory image
# E lines hold pc and instr of each expected commit, in program order
M 1c000000 02800001
M 1c000004 02800002
M 1c000008 02800003
M 1c00000c 02800004
M 1c000010 02800005
M 1c000014 50002000
M 1c000034 02800006
M 1c000038 50000c00
M 1c000044 02800007
M 1c000048 50000000
E 1c000000 02800001
E 1c000004 02800002
E 1c000008 02800003
E 1c00000c 02800004
E 1c000010 02800005
E 1c000014 50002000
E 1c000034 02800006
E 1c000038 50000c00
E 1c000044 02800007
E 1c000048 50000000
E 1c000048 50000000
